// ==== hw/pcie_link_consts.svh ====
`ifndef PCIE_LINK_CONSTS_SVH
`define PCIE_LINK_CONSTS_SVH

// Symbol codes, one per byte of the simplified ordered set
`define PCIE_COM_SYM 8'hBC  // Byte 3 of every set
`define PCIE_TS1_ID  8'h4A  // Byte 2 codes
`define PCIE_TS2_ID  8'h45
`define PCIE_IDL_ID  8'h7C
`define PCIE_PAD_SYM 8'hF7  // Unassigned link or lane

// Numbers this port offers during Configuration
`define PCIE_LINK_NUM 8'h01
`define PCIE_LANE_NUM 8'h00

// Consecutive matching sets needed to advance
`define PCIE_OS_RUN 8

// Timer limits in clock cycles
`define PCIE_DETECT_CYCLES  64
`define PCIE_POLL_TIMEOUT   1024
`define PCIE_RX_LOSS_CYCLES 128

`endif

// ==== hw/pcie_link_pkg.sv ====
`default_nettype none

package pcie_link_pkg;

  // One received or transmitted symbol word
  typedef logic [31:0] sym_word_t;

  // Single symbol byte within a word
  typedef logic [7:0] sym_byte_t;

  // Run length of consecutive sets, saturates at the advance count
  typedef logic [3:0] os_count_t;

  // Shared LTSSM timer
  typedef logic [15:0] ltssm_timer_t;

  // Training states kept in this design
  typedef enum logic [3:0] {
    ST_DETECT_QUIET     = 4'd0,
    ST_DETECT_ACTIVE    = 4'd1,
    ST_POLLING_ACTIVE   = 4'd2,
    ST_POLLING_CONFIG   = 4'd3,
    ST_CONFIG_LINKWIDTH = 4'd4,
    ST_CONFIG_IDLE      = 4'd5,
    ST_L0               = 4'd6,
    ST_RECOVERY         = 4'd7
  } ltssm_state_e;

endpackage

`default_nettype wire

// ==== hw/pcie_os_decoder.sv ====
`default_nettype none

`include "pcie_link_consts.svh"

module pcie_os_decoder import pcie_link_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  sym_word_t rx_data_i,
  input  logic      rx_valid_i,
  input  logic      rx_error_i,  // Decode error, sampled with rx_valid_i
  input  logic      os_clear_i,  // State change in the LTSSM
  output logic      ts1_run_o,
  output logic      ts2_run_o,
  output logic      ts2_link_run_o,
  output logic      idle_run_o,
  output logic      ts1_hit_o,
  output logic      rx_seen_o
);

  localparam os_count_t run_max = os_count_t'(`PCIE_OS_RUN);

  sym_byte_t com_byte;
  sym_byte_t type_byte;
  sym_byte_t link_byte;
  logic      good_com;
  logic      is_ts1;
  logic      is_ts2;
  logic      is_idl;
  logic      is_linked;
  os_count_t ts1_cnt;
  os_count_t ts2_cnt;
  os_count_t ts2_link_cnt;
  os_count_t idle_cnt;
  logic      ts1_q;  // First stage of the hit pulse

  function automatic os_count_t sat_inc(input os_count_t cnt);
    if (cnt == run_max) begin
      return cnt;
    end
    return os_count_t'(cnt + 1'b1);
  endfunction

  assign com_byte  = rx_data_i[31:24];
  assign type_byte = rx_data_i[23:16];
  assign link_byte = rx_data_i[15:8];

  // Error words never classify, so they clear every run
  assign good_com  = rx_valid_i && !rx_error_i && (com_byte == `PCIE_COM_SYM);
  assign is_ts1    = good_com && (type_byte == `PCIE_TS1_ID);
  assign is_ts2    = good_com && (type_byte == `PCIE_TS2_ID);
  assign is_idl    = good_com && (type_byte == `PCIE_IDL_ID);
  assign is_linked = is_ts2 && (link_byte == `PCIE_LINK_NUM);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ts1_cnt      <= '0;
      ts2_cnt      <= '0;
      ts2_link_cnt <= '0;
      idle_cnt     <= '0;
      ts1_q        <= 1'b0;
    end else if (os_clear_i) begin
      ts1_cnt      <= '0;  // Drop sets seen in the old state
      ts2_cnt      <= '0;
      ts2_link_cnt <= '0;
      idle_cnt     <= '0;
      ts1_q        <= 1'b0;
    end else begin
      ts1_q <= is_ts1;
      if (rx_valid_i) begin
        ts1_cnt      <= is_ts1 ? sat_inc(ts1_cnt) : '0;
        ts2_cnt      <= is_ts2 ? sat_inc(ts2_cnt) : '0;
        ts2_link_cnt <= is_linked ? sat_inc(ts2_link_cnt) : '0;
        idle_cnt     <= is_idl ? sat_inc(idle_cnt) : '0;
      end
    end
  end

  // Flags follow the counters by one register
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ts1_run_o      <= 1'b0;
      ts2_run_o      <= 1'b0;
      ts2_link_run_o <= 1'b0;
      idle_run_o     <= 1'b0;
      ts1_hit_o      <= 1'b0;
      rx_seen_o      <= 1'b0;
    end else begin
      rx_seen_o <= rx_valid_i;
      if (os_clear_i) begin
        ts1_run_o      <= 1'b0;
        ts2_run_o      <= 1'b0;
        ts2_link_run_o <= 1'b0;
        idle_run_o     <= 1'b0;
        ts1_hit_o      <= 1'b0;
      end else begin
        ts1_run_o      <= (ts1_cnt == run_max);
        ts2_run_o      <= (ts2_cnt == run_max);
        ts2_link_run_o <= (ts2_link_cnt == run_max);
        idle_run_o     <= (idle_cnt == run_max);
        ts1_hit_o      <= ts1_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/pcie_ltssm.sv ====
`default_nettype none

`include "pcie_link_consts.svh"

module pcie_ltssm import pcie_link_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         detect_i,           // Receiver detected on the lane
  input  logic         elec_idle_break_i,  // Cuts the Detect.Quiet wait short
  input  logic         ts1_run_i,
  input  logic         ts2_run_i,
  input  logic         ts2_link_run_i,
  input  logic         idle_run_i,
  input  logic         ts1_hit_i,
  input  logic         rx_seen_i,
  output ltssm_state_e state_o,
  output logic         os_clear_o,
  output logic         linkup_o,
  output logic         link_training_o
);

  // Last timer value before each limit fires
  localparam ltssm_timer_t detect_last = ltssm_timer_t'(`PCIE_DETECT_CYCLES - 1);
  localparam ltssm_timer_t poll_last   = ltssm_timer_t'(`PCIE_POLL_TIMEOUT - 1);
  localparam ltssm_timer_t loss_last   = ltssm_timer_t'(`PCIE_RX_LOSS_CYCLES - 1);

  ltssm_state_e state_q;
  ltssm_state_e state_d;
  ltssm_timer_t timer_q;
  ltssm_timer_t timer_d;
  logic         state_change;
  logic         poll_expired;

  always_ff @(posedge clk_i or posedge rst_i) begin : ltssm_seq
    if (rst_i) begin
      state_q         <= ST_DETECT_QUIET;
      timer_q         <= '0;
      linkup_o        <= 1'b0;
      link_training_o <= 1'b0;
    end else begin
      state_q  <= state_d;
      timer_q  <= timer_d;
      linkup_o <= (state_d == ST_L0) || (state_d == ST_RECOVERY);
      link_training_o <= state_d inside {ST_POLLING_ACTIVE, ST_POLLING_CONFIG,
                                         ST_CONFIG_LINKWIDTH, ST_CONFIG_IDLE,
                                         ST_RECOVERY};
    end
  end

  assign poll_expired = (timer_q >= poll_last);

  always_comb begin : ltssm_comb
    state_d = state_q;
    case (state_q)
      ST_DETECT_QUIET: begin
        if (elec_idle_break_i || (timer_q >= detect_last)) begin
          state_d = ST_DETECT_ACTIVE;
        end
      end
      ST_DETECT_ACTIVE: begin
        // Single cycle look at the receiver
        state_d = detect_i ? ST_POLLING_ACTIVE : ST_DETECT_QUIET;
      end
      ST_POLLING_ACTIVE: begin
        if (ts1_run_i || ts2_run_i) begin
          state_d = ST_POLLING_CONFIG;
        end else if (poll_expired) begin
          state_d = ST_DETECT_QUIET;
        end
      end
      ST_POLLING_CONFIG: begin
        if (ts2_run_i) begin
          state_d = ST_CONFIG_LINKWIDTH;
        end else if (poll_expired) begin
          state_d = ST_DETECT_QUIET;
        end
      end
      ST_CONFIG_LINKWIDTH: begin
        if (ts2_link_run_i) begin  // Partner echoed our link number
          state_d = ST_CONFIG_IDLE;
        end else if (poll_expired) begin
          state_d = ST_DETECT_QUIET;
        end
      end
      ST_CONFIG_IDLE: begin
        if (idle_run_i) begin
          state_d = ST_L0;
        end else if (poll_expired) begin
          state_d = ST_DETECT_QUIET;
        end
      end
      ST_L0: begin
        if (ts1_hit_i) begin
          state_d = ST_RECOVERY;
        end else if (timer_q >= loss_last) begin
          state_d = ST_DETECT_QUIET;  // Receiver went silent
        end
      end
      ST_RECOVERY: begin
        if (ts2_link_run_i) begin
          state_d = ST_CONFIG_IDLE;
        end else if (poll_expired) begin
          state_d = ST_DETECT_QUIET;
        end
      end
      default: begin
        state_d = ST_DETECT_QUIET;
      end
    endcase
  end

  assign state_change = (state_d != state_q);

  // Timer restarts on entry to each state
  always_comb begin : timer_comb
    if (state_change) begin
      timer_d = '0;
    end else if ((state_q == ST_L0) && rx_seen_i) begin
      timer_d = '0;  // Measures receive silence in L0
    end else begin
      timer_d = ltssm_timer_t'(timer_q + 1'b1);
    end
  end

  // Clears the decoder runs on the same edge as the state update
  assign os_clear_o = state_change;
  assign state_o    = state_q;

endmodule

`default_nettype wire

// ==== hw/pcie_os_generator.sv ====
`default_nettype none

`include "pcie_link_consts.svh"

module pcie_os_generator import pcie_link_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  ltssm_state_e state_i,
  output sym_word_t    tx_data_o,
  output logic         tx_valid_o
);

  sym_byte_t type_sym;
  sym_byte_t link_sym;
  sym_byte_t lane_sym;
  logic      send;

  always_comb begin
    type_sym = '0;
    link_sym = `PCIE_PAD_SYM;
    lane_sym = `PCIE_PAD_SYM;
    send     = 1'b0;
    case (state_i)
      ST_POLLING_ACTIVE, ST_RECOVERY: begin
        send     = 1'b1;
        type_sym = `PCIE_TS1_ID;
      end
      ST_POLLING_CONFIG: begin
        send     = 1'b1;
        type_sym = `PCIE_TS2_ID;
      end
      ST_CONFIG_LINKWIDTH: begin
        // Offer our link and lane numbers
        send     = 1'b1;
        type_sym = `PCIE_TS2_ID;
        link_sym = `PCIE_LINK_NUM;
        lane_sym = `PCIE_LANE_NUM;
      end
      ST_CONFIG_IDLE: begin
        send     = 1'b1;
        type_sym = `PCIE_IDL_ID;
        link_sym = `PCIE_LINK_NUM;  // Link is configured by now
        lane_sym = `PCIE_LANE_NUM;
      end
      default: begin
        send = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tx_valid_o <= 1'b0;
      tx_data_o  <= '0;
    end else begin
      tx_valid_o <= send;
      tx_data_o  <= send ? {`PCIE_COM_SYM, type_sym, link_sym, lane_sym} : '0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/pcie_link_top.sv ====
`default_nettype none

module pcie_link_top import pcie_link_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Receive side from the PHY
  input  sym_word_t rx_data_i,
  input  logic      rx_valid_i,
  input  logic      rx_error_i,
  input  logic      detect_i,
  input  logic      elec_idle_break_i,
  // Transmit side to the PHY
  output sym_word_t tx_data_o,
  output logic      tx_valid_o,
  output logic      linkup_o,
  output logic      link_training_o
);

  ltssm_state_e state;
  logic         os_clear;
  logic         ts1_run;
  logic         ts2_run;
  logic         ts2_link_run;
  logic         idle_run;
  logic         ts1_hit;
  logic         rx_seen;

  pcie_os_decoder pcie_os_decoder_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .rx_data_i      (rx_data_i),
    .rx_valid_i     (rx_valid_i),
    .rx_error_i     (rx_error_i),
    .os_clear_i     (os_clear),
    .ts1_run_o      (ts1_run),
    .ts2_run_o      (ts2_run),
    .ts2_link_run_o (ts2_link_run),
    .idle_run_o     (idle_run),
    .ts1_hit_o      (ts1_hit),
    .rx_seen_o      (rx_seen)
  );

  pcie_ltssm pcie_ltssm_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .detect_i          (detect_i),
    .elec_idle_break_i (elec_idle_break_i),
    .ts1_run_i         (ts1_run),
    .ts2_run_i         (ts2_run),
    .ts2_link_run_i    (ts2_link_run),
    .idle_run_i        (idle_run),
    .ts1_hit_i         (ts1_hit),
    .rx_seen_i         (rx_seen),
    .state_o           (state),
    .os_clear_o        (os_clear),
    .linkup_o          (linkup_o),
    .link_training_o   (link_training_o)
  );

  // Transmit set follows the state by one register
  pcie_os_generator pcie_os_generator_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .state_i    (state),
    .tx_data_o  (tx_data_o),
    .tx_valid_o (tx_valid_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_link_tasks.svh ====
`ifndef TB_LINK_TASKS_SVH
`define TB_LINK_TASKS_SVH

// Random source, stepped one bit at a time
logic [15:0] lfsr_q = 16'd45;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

task automatic rand_bits(input int n, output logic [15:0] v);
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    v      = {v[14:0], lfsr_q[0]};
  end
endtask

function automatic sym_word_t ts1_word(input sym_byte_t link, input sym_byte_t lane);
  return {`PCIE_COM_SYM, `PCIE_TS1_ID, link, lane};
endfunction

function automatic sym_word_t ts2_word(input sym_byte_t link, input sym_byte_t lane);
  return {`PCIE_COM_SYM, `PCIE_TS2_ID, link, lane};
endfunction

function automatic sym_word_t idle_word(input sym_byte_t link, input sym_byte_t lane);
  return {`PCIE_COM_SYM, `PCIE_IDL_ID, link, lane};
endfunction

task automatic fail_run(input string msg);
  $display("%s", msg);
  $display("sim failed");
  $fatal(1, "run stopped at the first error");
endtask

task automatic check_word(input string name, input sym_word_t exp, input sym_word_t act);
  if (act !== exp) begin
    fail_run($sformatf("CHECK FAILED %s: expected %h actual %h", name, exp, act));
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    fail_run($sformatf("CHECK FAILED %s: expected %b actual %b", name, exp, act));
  end
endtask

// Receive side stays quiet while waiting
task automatic wait_cycles(input int n);
  for (int i = 0; i < n; i++) begin
    @(posedge clk);
    rx_valid <= 1'b0;
    rx_error <= 1'b0;
  end
endtask

task automatic wait_tx_type(input string name, input logic exp_valid,
                            input sym_word_t exp_word, input int limit);
  int n;
  n = 0;
  @(negedge clk);
  while (!((tx_valid === exp_valid) && (tx_data === exp_word))) begin
    if (n >= limit) begin
      fail_run($sformatf("%s: transmit set %h did not appear within %0d cycles",
                         name, exp_word, limit));
    end
    n++;
    @(negedge clk);
  end
endtask

task automatic wait_linkup(input string name, input logic exp, input int limit);
  int n;
  n = 0;
  @(negedge clk);
  while (linkup !== exp) begin
    if (n >= limit) begin
      fail_run($sformatf("%s: linkup never reached %b within %0d cycles", name, exp, limit));
    end
    n++;
    @(negedge clk);
  end
endtask

`endif

// ==== test/tb_pcie_link.sv ====
`default_nettype none

`include "pcie_link_consts.svh"

module tb_pcie_link import pcie_link_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int run_len = `PCIE_OS_RUN;

  logic      clk;
  logic      rst;
  sym_word_t rx_data;
  logic      rx_valid;
  logic      rx_error;
  logic      detect;
  logic      elec_idle_break;
  sym_word_t tx_data;
  logic      tx_valid;
  logic      linkup;
  logic      link_training;

  // Expected state and run lengths from the words sent
  ltssm_state_e model_state;
  int           ts1_len;
  int           ts2_len;
  int           link_len;
  int           idle_len;

  `include "tb_link_tasks.svh"

  pcie_link_top pcie_link_top_i (
    .clk_i             (clk),
    .rst_i             (rst),
    .rx_data_i         (rx_data),
    .rx_valid_i        (rx_valid),
    .rx_error_i        (rx_error),
    .detect_i          (detect),
    .elec_idle_break_i (elec_idle_break),
    .tx_data_o         (tx_data),
    .tx_valid_o        (tx_valid),
    .linkup_o          (linkup),
    .link_training_o   (link_training)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic sym_word_t expected_tx(input ltssm_state_e st);
    case (st)
      ST_POLLING_ACTIVE, ST_RECOVERY: return ts1_word(`PCIE_PAD_SYM, `PCIE_PAD_SYM);
      ST_POLLING_CONFIG:              return ts2_word(`PCIE_PAD_SYM, `PCIE_PAD_SYM);
      ST_CONFIG_LINKWIDTH:            return ts2_word(`PCIE_LINK_NUM, `PCIE_LANE_NUM);
      ST_CONFIG_IDLE:                 return idle_word(`PCIE_LINK_NUM, `PCIE_LANE_NUM);
      default:                        return '0;  // Nothing sent outside training
    endcase
  endfunction

  function automatic logic expected_linkup(input ltssm_state_e st);
    return (st == ST_L0) || (st == ST_RECOVERY);
  endfunction

  function automatic logic expected_training(input ltssm_state_e st);
    return st inside {ST_POLLING_ACTIVE, ST_POLLING_CONFIG, ST_CONFIG_LINKWIDTH,
                      ST_CONFIG_IDLE, ST_RECOVERY};
  endfunction

  // Saturating run step
  function automatic int bump(input logic hit, input int len);
    return hit ? ((len < run_len) ? len + 1 : len) : 0;
  endfunction

  task automatic set_state(input ltssm_state_e st);
    model_state = st;
    ts1_len     = 0;
    ts2_len     = 0;
    link_len    = 0;
    idle_len    = 0;
  endtask

  task automatic model_word(input sym_word_t w, input logic err);
    logic         com;
    logic         t1;
    logic         t2;
    logic         idl;
    ltssm_state_e next;
    com      = !err && (w[31:24] == `PCIE_COM_SYM);
    t1       = com && (w[23:16] == `PCIE_TS1_ID);
    t2       = com && (w[23:16] == `PCIE_TS2_ID);
    idl      = com && (w[23:16] == `PCIE_IDL_ID);
    ts1_len  = bump(t1, ts1_len);
    ts2_len  = bump(t2, ts2_len);
    link_len = bump(t2 && (w[15:8] == `PCIE_LINK_NUM), link_len);
    idle_len = bump(idl, idle_len);
    next     = model_state;
    case (model_state)
      ST_POLLING_ACTIVE:   if ((ts1_len == run_len) || (ts2_len == run_len)) next = ST_POLLING_CONFIG;
      ST_POLLING_CONFIG:   if (ts2_len == run_len) next = ST_CONFIG_LINKWIDTH;
      ST_CONFIG_LINKWIDTH: if (link_len == run_len) next = ST_CONFIG_IDLE;
      ST_CONFIG_IDLE:      if (idle_len == run_len) next = ST_L0;
      ST_L0:               if (t1) next = ST_RECOVERY;  // Any single TS1
      ST_RECOVERY:         if (link_len == run_len) next = ST_CONFIG_IDLE;
      default:             next = model_state;
    endcase
    if (next != model_state) begin
      set_state(next);
    end
  endtask

  // Transmit set must not move until the model advances
  task automatic send_word(input string name, input sym_word_t w, input logic err);
    logic [15:0] gap;
    rand_bits(2, gap);
    @(posedge clk);
    rx_data  <= w;
    rx_valid <= 1'b1;
    rx_error <= err;
    @(negedge clk);
    check_word(name, expected_tx(model_state), tx_data);
    check_bit(name, expected_linkup(model_state), linkup);
    model_word(w, err);
    wait_cycles(gap);
  endtask

  task automatic settle(input string name);
    wait_cycles(1);
    wait_tx_type(name, expected_tx(model_state) != 32'h0, expected_tx(model_state), 16);
    check_bit(name, expected_linkup(model_state), linkup);
    check_bit(name, expected_training(model_state), link_training);
  endtask

  // One broken run and then good sets until the model advances
  task automatic run_stage(input string name, input sym_byte_t kind, input sym_byte_t link);
    ltssm_state_e start;
    logic [15:0]  r;
    logic [15:0]  brk_at;
    logic [15:0]  brk_kind;
    int           sent;
    start = model_state;
    rand_bits(3, brk_at);
    rand_bits(2, brk_kind);
    sent = 0;
    while (model_state == start) begin
      if (sent > 4 * run_len) begin
        fail_run($sformatf("%s: no state change after %0d words", name, sent));
      end
      rand_bits(8, r);  // Lane byte is ignored
      if (sent == brk_at) begin
        case (brk_kind)
          0:       send_word(name, {`PCIE_COM_SYM, kind, link, r[7:0]}, 1'b1);
          1:       send_word(name, {8'h3C, r[7:0], r[7:0], r[7:0]}, 1'b0);  // No comma
          default: send_word(name, ts2_word({1'b1, r[6:0]}, r[7:0]), 1'b0);  // Foreign link
        endcase
      end else begin
        send_word(name, {`PCIE_COM_SYM, kind, link, r[7:0]}, 1'b0);
      end
      sent++;
    end
    settle(name);
  endtask

  initial begin
    rst             = 1'b1;
    rx_data         = '0;
    rx_valid        = 1'b0;
    rx_error        = 1'b0;
    detect          = 1'b0;
    elec_idle_break = 1'b0;
    set_state(ST_DETECT_QUIET);
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit("reset linkup", 1'b0, linkup);
    check_bit("reset training", 1'b0, link_training);
    check_bit("reset tx_valid", 1'b0, tx_valid);

    // No receiver present
    for (int i = 0; i < 4 * `PCIE_DETECT_CYCLES; i++) begin
      @(negedge clk);
      check_bit("no detect tx_valid", 1'b0, tx_valid);
      check_bit("no detect training", 1'b0, link_training);
    end

    @(posedge clk);
    detect <= 1'b1;
    wait_tx_type("detect ts1", 1'b1, ts1_word(`PCIE_PAD_SYM, `PCIE_PAD_SYM),
                 2 * `PCIE_DETECT_CYCLES + 8);
    set_state(ST_POLLING_ACTIVE);
    check_bit("detect training", 1'b1, link_training);

    // Silent partner during polling
    wait_tx_type("poll timeout", 1'b0, '0, `PCIE_POLL_TIMEOUT + 8);
    set_state(ST_DETECT_QUIET);
    check_bit("poll timeout training", 1'b0, link_training);
    wait_tx_type("retrain ts1", 1'b1, ts1_word(`PCIE_PAD_SYM, `PCIE_PAD_SYM),
                 2 * `PCIE_DETECT_CYCLES + 8);
    set_state(ST_POLLING_ACTIVE);

    run_stage("polling ts1", `PCIE_TS1_ID, `PCIE_PAD_SYM);
    run_stage("polling ts2", `PCIE_TS2_ID, `PCIE_PAD_SYM);
    run_stage("linkwidth ts2", `PCIE_TS2_ID, `PCIE_LINK_NUM);
    run_stage("config idle", `PCIE_IDL_ID, `PCIE_PAD_SYM);

    send_word("l0 ts1", ts1_word(`PCIE_PAD_SYM, `PCIE_PAD_SYM), 1'b0);
    settle("recovery entry");
    run_stage("recovery ts2", `PCIE_TS2_ID, `PCIE_LINK_NUM);
    run_stage("recovery idle", `PCIE_IDL_ID, `PCIE_PAD_SYM);

    wait_linkup("rx loss", 1'b0, `PCIE_RX_LOSS_CYCLES + 16);
    set_state(ST_DETECT_QUIET);
    check_bit("rx loss tx_valid", 1'b0, tx_valid);
    check_bit("rx loss training", 1'b0, link_training);

    // Electrical idle exit cuts the quiet wait short
    @(posedge clk);
    elec_idle_break <= 1'b1;
    @(posedge clk);
    elec_idle_break <= 1'b0;
    wait_tx_type("idle break ts1", 1'b1, ts1_word(`PCIE_PAD_SYM, `PCIE_PAD_SYM), 8);
    set_state(ST_POLLING_ACTIVE);
    check_bit("idle break training", 1'b1, link_training);

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
+incdir+test
hw/pcie_link_pkg.sv
hw/pcie_os_decoder.sv
hw/pcie_ltssm.sv
hw/pcie_os_generator.sv
hw/pcie_link_top.sv
test/tb_pcie_link.sv
